// File: design/cpu6809_pkg.sv
// Shared definitions for the 6809-style core
// Address and data types, condition code bit positions,
// inherent opcode fields, ALU operation and sequencer state encodings

package cpu6809_pkg;

  // ------------------------------------------------------------------------
  // Basic types
  // ------------------------------------------------------------------------

  // Memory address and program counter value
  typedef logic [15:0] addr_t;

  // Data byte, opcode or accumulator value
  typedef logic [7:0] data_t;

  // ------------------------------------------------------------------------
  // Condition code register
  // ------------------------------------------------------------------------

  // Entire state saved
  localparam int unsigned CC_E = 7;
  // FIRQ mask
  localparam int unsigned CC_F = 6;
  // Half carry
  localparam int unsigned CC_H = 5;
  // IRQ mask
  localparam int unsigned CC_I = 4;
  // Negative
  localparam int unsigned CC_N = 3;
  // Zero
  localparam int unsigned CC_Z = 2;
  // Overflow
  localparam int unsigned CC_V = 1;
  // Carry
  localparam int unsigned CC_C = 0;

  // E, F and I set out of reset
  localparam data_t CC_RESET = 8'hD0;

  // ------------------------------------------------------------------------
  // Inherent opcode fields
  // ------------------------------------------------------------------------

  // Upper nibble picks the accumulator
  localparam logic [3:0] OPC_PAGE_A = 4'h4;
  localparam logic [3:0] OPC_PAGE_B = 4'h5;

  // Lower nibble picks the operation
  localparam logic [3:0] OPC_CLR = 4'hF;
  localparam logic [3:0] OPC_INC = 4'hC;
  localparam logic [3:0] OPC_ASL = 4'h8;
  localparam logic [3:0] OPC_ASR = 4'h7;
  localparam logic [3:0] OPC_LSR = 4'h4;
  localparam logic [3:0] OPC_COM = 4'h3;

  // ALU operation after decode
  typedef enum logic [2:0] {
    ALU_NONE,
    ALU_CLR,
    ALU_INC,
    ALU_ASL,
    ALU_ASR,
    ALU_LSR,
    ALU_COM
  } alu_op_t;

  // Master sequencer states, aligned with memory accesses
  typedef enum logic [2:0] {
    ST_VEC_HI,
    ST_VEC_LO,
    ST_FETCH,
    ST_EXEC,
    ST_HALT
  } seq_state_t;

endpackage

// File: design/cpu_sequencer.sv
// Master state machine of the core
// Owns the valid/ready read handshake, the instruction register
// and the one-cycle execute strobe

`timescale 1ns/10ps

module cpu_sequencer (
  input  logic                    clk,
  input  logic                    reset_b,
  input  logic                    halt_b,
  input  logic                    mem_ready,
  input  cpu6809_pkg::data_t      data_in,
  output logic                    mem_valid,
  output cpu6809_pkg::seq_state_t phase,
  output logic                    load_hi,
  output logic                    load_lo,
  output logic                    advance,
  output cpu6809_pkg::data_t      ir,
  output logic                    exec
);

  cpu6809_pkg::seq_state_t state;
  cpu6809_pkg::seq_state_t state_next;
  logic                    handshake;
  logic                    read_next;

  // Transfer completes on this edge
  assign handshake = mem_valid & mem_ready;

  // ------------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------------
  always_comb begin
    state_next = state;
    unique case (state)
      cpu6809_pkg::ST_VEC_HI: if (handshake) state_next = cpu6809_pkg::ST_VEC_LO;
      cpu6809_pkg::ST_VEC_LO: if (handshake) state_next = cpu6809_pkg::ST_FETCH;
      cpu6809_pkg::ST_FETCH:  if (handshake) state_next = cpu6809_pkg::ST_EXEC;
      // Always a single cycle, halt checked at the instruction boundary
      cpu6809_pkg::ST_EXEC:
        state_next = halt_b ? cpu6809_pkg::ST_FETCH : cpu6809_pkg::ST_HALT;
      cpu6809_pkg::ST_HALT:   if (halt_b) state_next = cpu6809_pkg::ST_FETCH;
      default:                state_next = cpu6809_pkg::ST_VEC_HI;
    endcase
  end

  // Read request follows the state we are heading into
  assign read_next = (state_next == cpu6809_pkg::ST_VEC_HI) ||
                     (state_next == cpu6809_pkg::ST_VEC_LO) ||
                     (state_next == cpu6809_pkg::ST_FETCH);

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state     <= cpu6809_pkg::ST_VEC_HI;
      mem_valid <= 1'b0;
    end else begin
      state     <= state_next;
      // Held while stalled, since state does not move without ready
      mem_valid <= read_next;
    end
  end

  // Opcode latch on the fetch handshake
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      ir <= 8'h00;
    end else if (handshake && (state == cpu6809_pkg::ST_FETCH)) begin
      ir <= data_in;
    end
  end

  // ------------------------------------------------------------------------
  // Pulses to the program counter, already qualified by the handshake
  // ------------------------------------------------------------------------
  assign load_hi = handshake && (state == cpu6809_pkg::ST_VEC_HI);
  assign load_lo = handshake && (state == cpu6809_pkg::ST_VEC_LO);
  assign advance = handshake && (state == cpu6809_pkg::ST_FETCH);

  assign exec  = (state == cpu6809_pkg::ST_EXEC);
  assign phase = state;

endmodule

// File: design/program_counter.sv
// Program counter of the core
// Reset vector load, post-fetch increment and fetch address select

`timescale 1ns/10ps

module program_counter #(
  parameter cpu6809_pkg::addr_t RESET_VECTOR = 16'hFFFE
) (
  input  logic                    clk,
  input  logic                    reset_b,
  input  cpu6809_pkg::seq_state_t phase,
  input  logic                    load_hi,
  input  logic                    load_lo,
  input  logic                    advance,
  input  cpu6809_pkg::data_t      data_in,
  output cpu6809_pkg::addr_t      mem_addr
);

  // Points at the next opcode to fetch
  cpu6809_pkg::addr_t pc_q;

  // ------------------------------------------------------------------------
  // Register update
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      pc_q <= 16'h0000;
    end else if (load_hi) begin
      // Big-endian vector, high byte first
      pc_q <= {data_in, 8'h00};
    end else if (load_lo) begin
      pc_q[7:0] <= data_in;
    end else if (advance) begin
      pc_q <= pc_q + 16'd1;
    end
  end

  // ------------------------------------------------------------------------
  // Address mux
  // ------------------------------------------------------------------------
  always_comb begin
    unique case (phase)
      cpu6809_pkg::ST_VEC_HI: mem_addr = RESET_VECTOR;
      cpu6809_pkg::ST_VEC_LO: mem_addr = RESET_VECTOR + 16'd1;
      // Fetch, execute and halt all show the PC
      default:                mem_addr = pc_q;
    endcase
  end

endmodule

// File: design/alu8.sv
// 8-bit ALU for the inherent accumulator instructions
// Opcode decode, shift and arithmetic results, condition code rules

`timescale 1ns/10ps

module alu8 (
  input  cpu6809_pkg::data_t ir,
  input  cpu6809_pkg::data_t operand,
  input  cpu6809_pkg::data_t cc,
  output cpu6809_pkg::data_t result,
  output cpu6809_pkg::data_t cc_next,
  output logic               write_en
);

  cpu6809_pkg::alu_op_t op;
  logic                 page_hit;

  // ------------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------------

  // Only the two inherent accumulator pages
  assign page_hit = (ir[7:4] == cpu6809_pkg::OPC_PAGE_A) ||
                    (ir[7:4] == cpu6809_pkg::OPC_PAGE_B);

  always_comb begin
    op = cpu6809_pkg::ALU_NONE;
    if (page_hit) begin
      unique case (ir[3:0])
        cpu6809_pkg::OPC_CLR: op = cpu6809_pkg::ALU_CLR;
        cpu6809_pkg::OPC_INC: op = cpu6809_pkg::ALU_INC;
        cpu6809_pkg::OPC_ASL: op = cpu6809_pkg::ALU_ASL;
        cpu6809_pkg::OPC_ASR: op = cpu6809_pkg::ALU_ASR;
        cpu6809_pkg::OPC_LSR: op = cpu6809_pkg::ALU_LSR;
        cpu6809_pkg::OPC_COM: op = cpu6809_pkg::ALU_COM;
        default:              op = cpu6809_pkg::ALU_NONE;
      endcase
    end
  end

  // Unknown opcodes behave as no-ops
  assign write_en = (op != cpu6809_pkg::ALU_NONE);

  // ------------------------------------------------------------------------
  // Result and flags
  // ------------------------------------------------------------------------
  always_comb begin
    result  = operand;
    cc_next = cc;

    unique case (op)
      cpu6809_pkg::ALU_CLR: begin
        result                   = 8'h00;
        cc_next[cpu6809_pkg::CC_V] = 1'b0;
        cc_next[cpu6809_pkg::CC_C] = 1'b0;
      end
      cpu6809_pkg::ALU_INC: begin
        result                   = operand + 8'd1;
        // Signed wrap from +127 only, carry untouched
        cc_next[cpu6809_pkg::CC_V] = (operand == 8'h7F);
      end
      cpu6809_pkg::ALU_ASL: begin
        result                   = {operand[6:0], 1'b0};
        cc_next[cpu6809_pkg::CC_C] = operand[7];
        cc_next[cpu6809_pkg::CC_V] = operand[7] ^ operand[6];
      end
      cpu6809_pkg::ALU_ASR: begin
        // Sign bit replicated, V left alone
        result                   = {operand[7], operand[7:1]};
        cc_next[cpu6809_pkg::CC_C] = operand[0];
      end
      cpu6809_pkg::ALU_LSR: begin
        result                   = {1'b0, operand[7:1]};
        cc_next[cpu6809_pkg::CC_C] = operand[0];
      end
      cpu6809_pkg::ALU_COM: begin
        result                   = ~operand;
        cc_next[cpu6809_pkg::CC_V] = 1'b0;
        cc_next[cpu6809_pkg::CC_C] = 1'b1;
      end
      default: begin
        result = operand;
      end
    endcase

    // N and Z follow the result for every operation
    cc_next[cpu6809_pkg::CC_N] = result[7];
    cc_next[cpu6809_pkg::CC_Z] = (result == 8'h00);

    // Mask and half carry bits pass through
    cc_next[cpu6809_pkg::CC_E] = cc[cpu6809_pkg::CC_E];
    cc_next[cpu6809_pkg::CC_F] = cc[cpu6809_pkg::CC_F];
    cc_next[cpu6809_pkg::CC_H] = cc[cpu6809_pkg::CC_H];
    cc_next[cpu6809_pkg::CC_I] = cc[cpu6809_pkg::CC_I];
  end

endmodule

// File: design/accumulator_file.sv
// Accumulators A and B and the condition code register
// Operand select by opcode bit 4, write-back in the execute cycle

`timescale 1ns/10ps

module accumulator_file (
  input  logic               clk,
  input  logic               reset_b,
  input  cpu6809_pkg::data_t ir,
  input  logic               exec,
  input  logic               write_en,
  input  cpu6809_pkg::data_t result,
  input  cpu6809_pkg::data_t cc_next,
  output cpu6809_pkg::data_t operand,
  output cpu6809_pkg::data_t cc,
  output cpu6809_pkg::data_t a_out,
  output cpu6809_pkg::data_t b_out
);

  cpu6809_pkg::data_t a_q;
  cpu6809_pkg::data_t b_q;
  cpu6809_pkg::data_t cc_q;
  logic               sel_b;
  logic               wr;

  // Page 0x5 targets B, page 0x4 targets A
  assign sel_b = ir[4];

  // Only a decoded instruction in its execute cycle writes
  assign wr = exec & write_en;

  // ------------------------------------------------------------------------
  // Register update
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_q  <= 8'h00;
      b_q  <= 8'h00;
      cc_q <= cpu6809_pkg::CC_RESET;
    end else if (wr) begin
      if (sel_b) begin
        b_q <= result;
      end else begin
        a_q <= result;
      end
      cc_q <= cc_next;
    end
  end

  // ALU source
  assign operand = sel_b ? b_q : a_q;

  // Observation and flag feedback
  assign cc    = cc_q;
  assign a_out = a_q;
  assign b_out = b_q;

endmodule

// File: design/cpu6809_core.sv
// Top level of the 6809-style front end
// Sequencer, program counter, ALU and accumulator file wired together

`timescale 1ns/10ps

module cpu6809_core #(
  parameter cpu6809_pkg::addr_t RESET_VECTOR = 16'hFFFE
) (
  input  logic               clk,
  input  logic               reset_b,
  input  logic               halt_b,
  output logic               mem_valid,
  input  logic               mem_ready,
  output cpu6809_pkg::addr_t mem_addr,
  input  cpu6809_pkg::data_t data_in,
  output cpu6809_pkg::data_t a_out,
  output cpu6809_pkg::data_t b_out,
  output cpu6809_pkg::data_t cc_out
);

  // ------------------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------------------

  // Sequencer to program counter
  cpu6809_pkg::seq_state_t phase;
  logic                    load_hi;
  logic                    load_lo;
  logic                    advance;

  // Instruction and execute strobe
  cpu6809_pkg::data_t ir;
  logic               exec;

  // Datapath
  cpu6809_pkg::data_t operand;
  cpu6809_pkg::data_t cc;
  cpu6809_pkg::data_t result;
  cpu6809_pkg::data_t cc_next;
  logic               write_en;

  // ------------------------------------------------------------------------
  // Instances
  // ------------------------------------------------------------------------
  cpu_sequencer i_cpu_sequencer (
    .clk       (clk),
    .reset_b   (reset_b),
    .halt_b    (halt_b),
    .mem_ready (mem_ready),
    .data_in   (data_in),
    .mem_valid (mem_valid),
    .phase     (phase),
    .load_hi   (load_hi),
    .load_lo   (load_lo),
    .advance   (advance),
    .ir        (ir),
    .exec      (exec)
  );

  program_counter #(
    .RESET_VECTOR (RESET_VECTOR)
  ) i_program_counter (
    .clk      (clk),
    .reset_b  (reset_b),
    .phase    (phase),
    .load_hi  (load_hi),
    .load_lo  (load_lo),
    .advance  (advance),
    .data_in  (data_in),
    .mem_addr (mem_addr)
  );

  alu8 i_alu8 (
    .ir       (ir),
    .operand  (operand),
    .cc       (cc),
    .result   (result),
    .cc_next  (cc_next),
    .write_en (write_en)
  );

  accumulator_file i_accumulator_file (
    .clk      (clk),
    .reset_b  (reset_b),
    .ir       (ir),
    .exec     (exec),
    .write_en (write_en),
    .result   (result),
    .cc_next  (cc_next),
    .operand  (operand),
    .cc       (cc),
    .a_out    (a_out),
    .b_out    (b_out)
  );

  // CC observed straight from the register
  assign cc_out = cc;

endmodule

// File: tb/tb_clock_gen.sv
// Clock and reset source for the testbench
// 8 ns clock, active-low reset held for four rising edges

`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic reset_b
);

  localparam int HALF_PERIOD_NS = 4;
  localparam int RESET_CYCLES   = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    reset_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_b = 1'b1;
  end

endmodule

// File: tb/cpu6809_checker.sv
// Concurrent assertions on the memory handshake and the halt state
// Bound into every cpu6809_core instance

`timescale 1ns/10ps

module cpu6809_checker (
  input logic                    clk,
  input logic                    reset_b,
  input logic                    halt_b,
  input logic                    mem_valid,
  input logic                    mem_ready,
  input cpu6809_pkg::addr_t      mem_addr,
  input cpu6809_pkg::seq_state_t phase
);

  // Running count of assertion failures
  int unsigned fail_count = 0;

  // Request frozen while memory holds ready low
  req_stable_a: assert property (
    @(posedge clk) disable iff (!reset_b)
    (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr))
  ) else begin
    $error("read request changed while waiting for ready");
    fail_count++;
  end

  // Opcode fetch always followed by the execute cycle
  exec_idle_a: assert property (
    @(posedge clk) disable iff (!reset_b)
    (mem_valid && mem_ready && (phase == cpu6809_pkg::ST_FETCH)) |=> !mem_valid
  ) else begin
    $error("read request raised in the cycle after an opcode fetch");
    fail_count++;
  end

  // No reads while halt_b holds the core at an instruction boundary
  halt_idle_a: assert property (
    @(posedge clk) disable iff (!reset_b)
    (((phase == cpu6809_pkg::ST_EXEC) || (phase == cpu6809_pkg::ST_HALT)) && !halt_b)
      |=> !mem_valid
  ) else begin
    $error("read request raised while halted");
    fail_count++;
  end

endmodule

bind cpu6809_core cpu6809_checker i_cpu6809_checker (
  .clk       (clk),
  .reset_b   (reset_b),
  .halt_b    (halt_b),
  .mem_valid (mem_valid),
  .mem_ready (mem_ready),
  .mem_addr  (mem_addr),
  .phase     (phase)
);

// File: tb/cpu6809_tb.sv
// Testbench for the 6809-style front end
// Memory model with LFSR stalls, reference model of A, B and CC,
// directed tests, watchdog and closing summary

`timescale 1ns/10ps

module cpu6809_tb;

  // --------------------------------------------------------------------------
  // Constants
  // --------------------------------------------------------------------------
  localparam int CLK_PERIOD_NS = 8;
  localparam int MAX_STALL     = 3;
  localparam int HOLD_CYCLES   = 12;
  localparam int MARGIN_CYCLES = 50;
  localparam int N_TESTS       = 5;
  // Instructions per test, in run order
  localparam int N_T1          = 1;
  localparam int N_T2          = 9;
  localparam int N_T3          = 14;
  localparam int N_T4          = 64;
  localparam int N_T5          = 4;
  localparam int N_INSTR_TOTAL = N_T1 + N_T2 + N_T3 + N_T4 + N_T5;
  localparam int WATCHDOG_NS   = (N_INSTR_TOTAL * (MAX_STALL + 3) +
                                  N_TESTS * MARGIN_CYCLES + HOLD_CYCLES) * CLK_PERIOD_NS;

  localparam cpu6809_pkg::addr_t VEC_ADDR = 16'hFFFE;
  localparam cpu6809_pkg::addr_t START_PC = 16'h1200;

  logic               clk;
  logic               reset_b;
  logic               halt_b;
  logic               mem_valid;
  logic               mem_ready = 1'b0;
  cpu6809_pkg::addr_t mem_addr;
  cpu6809_pkg::data_t data_in   = 8'h00;
  cpu6809_pkg::data_t a_out;
  cpu6809_pkg::data_t b_out;
  cpu6809_pkg::data_t cc_out;

  // Memory image and transfer log
  cpu6809_pkg::data_t mem [65536];
  cpu6809_pkg::addr_t xfer_addr [$];
  int                 fetch_count = 0;
  int                 stall_left  = 0;
  logic [31:0]        lfsr_q      = 32'h729e_5824;

  // Reference model state and next expected fetch address
  cpu6809_pkg::data_t ref_a;
  cpu6809_pkg::data_t ref_b;
  cpu6809_pkg::data_t ref_cc;
  cpu6809_pkg::addr_t exp_pc;

  int checks = 0;
  int errors = 0;

  tb_clock_gen i_tb_clock_gen (
    .clk     (clk),
    .reset_b (reset_b)
  );

  cpu6809_core i_cpu6809_core (
    .clk       (clk),
    .reset_b   (reset_b),
    .halt_b    (halt_b),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .data_in   (data_in),
    .a_out     (a_out),
    .b_out     (b_out),
    .cc_out    (cc_out)
  );

  // --------------------------------------------------------------------------
  // LFSR, taps 32 22 2 1
  // --------------------------------------------------------------------------
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // Inherent op on A or B, a quarter of them unknown low nibbles
  function automatic cpu6809_pkg::data_t random_opcode();
    logic [31:0] page_bit;
    logic [31:0] sel;
    logic [3:0]  low;
    page_bit = draw_bits(1);
    sel      = draw_bits(3);
    case (sel[2:0])
      3'd0:    low = 4'hF;
      3'd1:    low = 4'hC;
      3'd2:    low = 4'h8;
      3'd3:    low = 4'h7;
      3'd4:    low = 4'h4;
      3'd5:    low = 4'h3;
      3'd6:    low = 4'h0;
      default: low = 4'hA;
    endcase
    return {(page_bit[0] ? 4'h5 : 4'h4), low};
  endfunction

  // --------------------------------------------------------------------------
  // Memory model, ready and data change on the falling edge
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    data_in = mem[mem_addr];
    if (!mem_valid) begin
      mem_ready = 1'b0;
    end else if (stall_left > 0) begin
      mem_ready  = 1'b0;
      stall_left = stall_left - 1;
    end else begin
      // Transfer completes on the coming rising edge
      mem_ready = 1'b1;
      xfer_addr.push_back(mem_addr);
      if (mem_addr != VEC_ADDR && mem_addr != VEC_ADDR + 16'd1) begin
        fetch_count++;
      end
      stall_left = draw_bits(2);
    end
  end

  task automatic fill_memory();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'(i ^ (i >> 8) ^ 8'h5A);
    end
  endtask

  // Reference model of the inherent accumulator instructions
  task automatic model_exec(input cpu6809_pkg::data_t opc);
    cpu6809_pkg::data_t src;
    cpu6809_pkg::data_t res;
    cpu6809_pkg::data_t cc;
    logic               known;
    src   = opc[4] ? ref_b : ref_a;
    res   = src;
    cc    = ref_cc;
    known = (opc[7:4] == 4'h4) || (opc[7:4] == 4'h5);
    case (opc[3:0])
      4'hF: begin
        res                    = 8'h00;
        cc[cpu6809_pkg::CC_V] = 1'b0;
        cc[cpu6809_pkg::CC_C] = 1'b0;
      end
      4'hC: begin
        res                    = src + 8'd1;
        cc[cpu6809_pkg::CC_V] = (src == 8'h7F);
      end
      4'h8: begin
        res                    = {src[6:0], 1'b0};
        cc[cpu6809_pkg::CC_C] = src[7];
        cc[cpu6809_pkg::CC_V] = src[7] ^ src[6];
      end
      4'h7: begin
        res                    = {src[7], src[7:1]};
        cc[cpu6809_pkg::CC_C] = src[0];
      end
      4'h4: begin
        res                    = {1'b0, src[7:1]};
        cc[cpu6809_pkg::CC_C] = src[0];
      end
      4'h3: begin
        res                    = ~src;
        cc[cpu6809_pkg::CC_V] = 1'b0;
        cc[cpu6809_pkg::CC_C] = 1'b1;
      end
      default: known = 1'b0;
    endcase
    // Unknown opcodes leave every register alone
    if (known) begin
      cc[cpu6809_pkg::CC_N] = res[7];
      cc[cpu6809_pkg::CC_Z] = (res == 8'h00);
      if (opc[4]) begin
        ref_b = res;
      end else begin
        ref_a = res;
      end
      ref_cc = cc;
    end
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_regs();
    check_value("a_out", a_out, ref_a);
    check_value("b_out", b_out, ref_b);
    check_value("cc_out", cc_out, ref_cc);
  endtask

  task automatic check_next_xfer(input cpu6809_pkg::addr_t exp);
    cpu6809_pkg::addr_t got;
    checks++;
    assert (xfer_addr.size() != 0) else begin
      $display("Expected a read at 0x%h but no transfer was seen", exp);
      errors++;
    end
    if (xfer_addr.size() != 0) begin
      got = xfer_addr.pop_front();
      check_value("mem_addr", got, exp);
    end
  endtask

  // Consecutive opcode fetches from exp_pc
  task automatic check_fetch_addrs(input int n);
    for (int i = 0; i < n; i++) begin
      check_next_xfer(exp_pc);
      exp_pc = exp_pc + 16'd1;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - err_start);
    end
  endtask

  // Lift halt, count n opcode fetches, park again after the last one
  task automatic run_instrs(input int n);
    int target;
    target = fetch_count + n;
    @(negedge clk);
    halt_b = 1'b1;
    wait (fetch_count == target);
    halt_b = 1'b0;
    // Fetch edge, then the edge that ends ST_EXEC
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic step_and_check(input cpu6809_pkg::data_t opc);
    mem[exp_pc] = opc;
    run_instrs(1);
    model_exec(opc);
    check_fetch_addrs(1);
    check_regs();
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset_vector();
    int err_start;
    err_start                = errors;
    mem[VEC_ADDR]            = START_PC[15:8];
    mem[VEC_ADDR + 16'd1]    = START_PC[7:0];
    // 6809 NOP, outside both pages
    mem[START_PC]            = 8'h12;
    ref_a                    = 8'h00;
    ref_b                    = 8'h00;
    ref_cc                   = 8'hD0;
    wait (reset_b === 1'b1);
    @(negedge clk);
    check_regs();
    // First opcode runs before halt can take effect
    wait (fetch_count == N_T1);
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_next_xfer(VEC_ADDR);
    check_next_xfer(VEC_ADDR + 16'd1);
    exp_pc = {mem[VEC_ADDR], mem[VEC_ADDR + 16'd1]};
    model_exec(mem[exp_pc]);
    check_fetch_addrs(N_T1);
    check_regs();
    report_test("reset_vector", err_start);
  endtask

  task automatic test_acc_a();
    cpu6809_pkg::data_t prog [N_T2];
    int                 err_start;
    // COMA INCA COMA ASLA ASRA LSRA INCA ASLA CLRA
    prog      = '{8'h43, 8'h4C, 8'h43, 8'h48, 8'h47, 8'h44, 8'h4C, 8'h48, 8'h4F};
    err_start = errors;
    foreach (prog[i]) begin
      step_and_check(prog[i]);
    end
    report_test("acc_a", err_start);
  endtask

  task automatic test_acc_b_noop();
    cpu6809_pkg::data_t prog [N_T3];
    int                 err_start;
    // COMB LSRB ASRB INCB CLRB INCB ASLB COMB, then six no-ops
    prog      = '{8'h53, 8'h54, 8'h57, 8'h5C, 8'h5F, 8'h5C, 8'h58, 8'h53,
                  8'h12, 8'h40, 8'h5A, 8'h4D, 8'h01, 8'h6F};
    err_start = errors;
    foreach (prog[i]) begin
      step_and_check(prog[i]);
    end
    report_test("acc_b_noop", err_start);
  endtask

  task automatic test_back_pressure();
    cpu6809_pkg::data_t prog [N_T4];
    int                 err_start;
    err_start = errors;
    foreach (prog[i]) begin
      prog[i]              = random_opcode();
      mem[exp_pc + 16'(i)] = prog[i];
    end
    run_instrs(N_T4);
    foreach (prog[i]) begin
      model_exec(prog[i]);
    end
    check_fetch_addrs(N_T4);
    check_regs();
    report_test("back_pressure", err_start);
  endtask

  task automatic test_halt();
    cpu6809_pkg::data_t prog [N_T5];
    int                 err_start;
    // INCA INCB COMA ASLB
    prog      = '{8'h4C, 8'h5C, 8'h43, 8'h58};
    err_start = errors;
    foreach (prog[i]) begin
      mem[exp_pc + 16'(i)] = prog[i];
    end
    run_instrs(1);
    model_exec(prog[0]);
    check_fetch_addrs(1);
    check_regs();
    // Parked core must stay off the bus
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_value("mem_valid", mem_valid, 1'b0);
    end
    checks++;
    assert (xfer_addr.size() == 0) else begin
      $display("Memory transfer seen while the core was halted");
      errors++;
    end
    run_instrs(N_T5 - 1);
    for (int i = 1; i < N_T5; i++) begin
      model_exec(prog[i]);
    end
    check_fetch_addrs(N_T5 - 1);
    check_regs();
    report_test("halt", err_start);
  endtask

  // --------------------------------------------------------------------------
  // Watchdog
  // --------------------------------------------------------------------------
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int assert_fails;
    halt_b = 1'b0;
    fill_memory();
    test_reset_vector();
    test_acc_a();
    test_acc_b_noop();
    test_back_pressure();
    test_halt();
    assert_fails = i_cpu6809_core.i_cpu6809_checker.fail_count;
    $display("Summary: %0d tests, %0d checks, %0d check errors, %0d assertion failures",
             N_TESTS, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: cpu6809.f
design/cpu6809_pkg.sv
design/cpu_sequencer.sv
design/program_counter.sv
design/alu8.sv
design/accumulator_file.sv
design/cpu6809_core.sv
tb/tb_clock_gen.sv
tb/cpu6809_checker.sv
tb/cpu6809_tb.sv

// File: Bender.yml
package:
  name: cpu6809

sources:
  - files:
      - design/cpu6809_pkg.sv
      - design/cpu_sequencer.sv
      - design/program_counter.sv
      - design/alu8.sv
      - design/accumulator_file.sv
      - design/cpu6809_core.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/cpu6809_checker.sv
      - tb/cpu6809_tb.sv
